// ==== build.f ====
+incdir+tests
logic/sha256_pkg.sv
logic/sha_if.sv
logic/nonce_sequencer.sv
logic/sha256_core.sv
logic/rehash_stage.sv
logic/result_latch.sv
logic/sha256d_engine.sv
tests/tb_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_top -f build.f -o tb_top_sim
	./obj_dir/tb_top_sim | tee /dev/stderr | grep "Finished with no errors" > /dev/null

clean:
	rm -rf obj_dir

// ==== tests/sha256_ref.svh ====
// SHA-256 software model over byte messages and the prefix plus nonce double hash, for the testbench
`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

function automatic word_t rotate_right(input word_t x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One 64-byte block of msg starting at base, FIPS 180-4 section 6.2
function automatic digest_t compress_block(input digest_t hin, input logic [7:0] msg[$],
	input int base);
	word_t w [0:63];
	word_t s0, s1, t1, t2;
	digest_t v;
	for (int t = 0; t < 16; t++)
		w[t] = {msg[base + 4*t], msg[base + 4*t + 1], msg[base + 4*t + 2], msg[base + 4*t + 3]};
	for (int t = 16; t < 64; t++) begin		// Schedule expansion
		s0 = rotate_right(w[t-15], 7) ^ rotate_right(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = rotate_right(w[t-2], 17) ^ rotate_right(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	v = hin;		// a..h
	for (int t = 0; t < 64; t++) begin
		s1 = rotate_right(v[4], 6) ^ rotate_right(v[4], 11) ^ rotate_right(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + ROUND_K[t] + w[t];
		s0 = rotate_right(v[0], 2) ^ rotate_right(v[0], 13) ^ rotate_right(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		v = {t1 + t2, v[0], v[1], v[2], v[3] + t1, v[4], v[5], v[6]};
	end
	for (int i = 0; i < 8; i++)
		v[i] = v[i] + hin[i];
	return v;
endfunction

// Full hash with standard padding, any length
function automatic digest_t hash_bytes(input logic [7:0] msg[$]);
	logic [7:0] pad[$];
	logic [63:0] bit_len;
	digest_t hv;
	pad = msg;
	bit_len = 64'(msg.size() * 8);
	pad.push_back(8'h80);
	while (pad.size() % 64 != 56)
		pad.push_back(8'h00);
	for (int i = 7; i >= 0; i--)
		pad.push_back(bit_len[8*i +: 8]);		// Length, big-endian
	hv = HASH_INIT;
	for (int base = 0; base < pad.size(); base += 64)
		hv = compress_block(hv, pad, base);
	return hv;
endfunction

// SHA-256 of SHA-256 of prefix then nonce, 68 bytes
function automatic digest_t double_hash(input block_t prefix, input word_t nonce);
	logic [7:0] msg[$];
	digest_t first_digest;
	for (int i = 0; i < 16; i++)
		for (int j = 3; j >= 0; j--)
			msg.push_back(prefix[i][8*j +: 8]);
	for (int j = 3; j >= 0; j--)
		msg.push_back(nonce[8*j +: 8]);
	first_digest = hash_bytes(msg);
	msg.delete();
	for (int i = 0; i < 8; i++)
		for (int j = 3; j >= 0; j--)
			msg.push_back(first_digest[i][8*j +: 8]);
	return hash_bytes(msg);
endfunction

`endif

// ==== tests/tb_top.sv ====
// Testbench for the double SHA-256 engine; directed tests checked against a software hash model
`timescale 1ns/100ps

module tb_top;
	import sha256_pkg::*;

	`include "sha256_ref.svh"

	localparam int WATCHDOG_CYCLES = 40 * 200 + 2000;		// 40 results plus drain margin
	localparam int QUIET_CYCLES = 300;						// No result this long means drained

	logic clk;
	logic reset;
	logic run;
	block_t prefix_block;
	logic result_valid;
	digest_t result_digest;
	word_t result_nonce;
	logic [OP_COUNT_WIDTH - 1:0] op_count;

	integer seed;
	word_t next_nonce;		// Nonce the next result must carry
	int result_total;		// result_valid pulses since reset

	sha256d_engine i_sha256d_engine (
		.clk(clk),
		.reset(reset),
		.run(run),
		.prefix_block(prefix_block),
		.result_valid(result_valid),
		.result_digest(result_digest),
		.result_nonce(result_nonce),
		.op_count(op_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not complete within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		$display("Finished with errors");
		$fatal(1, "stopping at first error");
	endtask

	task automatic load_prefix();
		for (int i = 0; i < 16; i++)
			prefix_block[i] = $random(seed);
	endtask

	// Called on the negedge where result_valid is high
	task automatic check_result();
		digest_t expected;
		expected = double_hash(prefix_block, next_nonce);
		assert (result_nonce == next_nonce) else
			report_error($sformatf("nonce %0h, expected %0h", result_nonce, next_nonce));
		assert (result_digest == expected) else
			report_error($sformatf("nonce %0h digest %h, expected %h", result_nonce,
				result_digest, expected));
		next_nonce = next_nonce + 32'd1;
		result_total++;
	endtask

	task automatic wait_result();
		do
			@(negedge clk);
		while (!result_valid);
		check_result();
	endtask

	// In-flight items still finish after run drops
	task automatic drain_results();
		int quiet;
		quiet = 0;
		while (quiet < QUIET_CYCLES) begin
			@(negedge clk);
			if (result_valid) begin
				check_result();
				quiet = 0;
			end else begin
				quiet++;
			end
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic reset_state();
		repeat (20) begin
			@(negedge clk);
			assert (!result_valid) else report_error("result_valid high with run low");
		end
		assert (op_count == '0) else report_error($sformatf("op_count %0d after reset", op_count));
	endtask

	task automatic single_nonce();
		@(negedge clk);
		load_prefix();
		run = 1'b1;
		wait_result();
		run = 1'b0;		// Same negedge as the first result
		drain_results();
	endtask

	task automatic continuous_run();
		@(negedge clk);
		run = 1'b1;		// Prefix resent with the same value
		repeat (8) wait_result();
		run = 1'b0;
		drain_results();
	endtask

	task automatic new_prefix();
		@(negedge clk);
		load_prefix();		// Midstate rebuilt on the next run
		run = 1'b1;
		repeat (4) wait_result();
		run = 1'b0;
		drain_results();
	endtask

	task automatic op_count_total();
		@(negedge clk);
		assert (op_count == OP_COUNT_WIDTH'(result_total)) else
			report_error($sformatf("op_count %0d, counted %0d results", op_count, result_total));
	endtask

	initial begin
		seed = 32'h778c_61fb;
		reset = 1'b1;
		run = 1'b0;
		prefix_block = '0;
		next_nonce = '0;
		result_total = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		reset_state();
		single_nonce();
		continuous_run();
		new_prefix();
		op_count_total();

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== logic/sha256d_engine.sv ====
// Double SHA-256 engine top level; hashes prefix_block plus a running nonce while run is high
`timescale 1ns/100ps

module sha256d_engine (
	input logic clk,
	input logic reset,
	input logic run,							// Hold high to keep issuing nonces
	input sha256_pkg::block_t prefix_block,		// Sampled when the prefix is sent
	output logic result_valid,
	output sha256_pkg::digest_t result_digest,
	output sha256_pkg::word_t result_nonce,
	output logic [sha256_pkg::OP_COUNT_WIDTH - 1:0] op_count
);

	////////////////////////////////////////
	// Pipeline links
	////////////////////////////////////////

	sha_block_if first_req ();			// Sequencer to core one
	sha_digest_if first_digest ();		// Core one to rehash
	sha_block_if second_req ();			// Rehash to core two
	sha_digest_if final_digest ();		// Core two to result

	nonce_sequencer i_nonce_sequencer (
		.clk(clk),
		.reset(reset),
		.run(run),
		.prefix_block(prefix_block),
		.req(first_req.source)
	);

	// Prefix midstate lives in core one
	sha256_core i_first_core (.clk(clk), .reset(reset), .req(first_req.sink),
		.rsp(first_digest.source));

	rehash_stage i_rehash_stage (.clk(clk), .reset(reset), .in_digest(first_digest.sink),
		.out_req(second_req.source));

	sha256_core i_second_core (.clk(clk), .reset(reset), .req(second_req.sink),
		.rsp(final_digest.source));

	result_latch i_result_latch (
		.clk(clk),
		.reset(reset),
		.in_digest(final_digest.sink),
		.result_valid(result_valid),
		.result_digest(result_digest),
		.result_nonce(result_nonce),
		.op_count(op_count)
	);

endmodule

// ==== logic/result_latch.sv ====
// Final stage: captures each double-hash result with its nonce and counts completed hashes
`timescale 1ns/100ps

module result_latch (
	input logic clk,
	input logic reset,
	sha_digest_if.sink in_digest,		// From core two
	output logic result_valid,			// One cycle per result
	output sha256_pkg::digest_t result_digest,
	output sha256_pkg::word_t result_nonce,
	output logic [sha256_pkg::OP_COUNT_WIDTH - 1:0] op_count
);

	logic take;

	assign in_digest.ready = 1'b1;		// Never stalls core two
	assign take = in_digest.valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			op_count <= '0;
		end else begin
			result_valid <= take;
			if (take)
				op_count <= op_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			result_digest <= in_digest.digest;
			result_nonce <= in_digest.tag;
		end
	end

endmodule

// ==== logic/rehash_stage.sv ====
// Holds one first-pass digest and offers it, padded to a block, to the second core
`timescale 1ns/100ps

module rehash_stage (
	input logic clk,
	input logic reset,
	sha_digest_if.sink in_digest,		// From core one
	sha_block_if.source out_req			// To core two
);
	import sha256_pkg::*;

	logic full;
	digest_t hold_digest;
	word_t hold_tag;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (in_digest.valid && in_digest.ready) begin
			full <= 1'b1;
		end else if (out_req.valid && out_req.ready) begin
			full <= 1'b0;		// Core two took it
		end
	end

	// Payload only, qualified by full
	always_ff @(posedge clk) begin
		if (in_digest.valid && in_digest.ready) begin
			hold_digest <= in_digest.digest;
			hold_tag <= in_digest.tag;
		end
	end

	assign in_digest.ready = !full;
	assign out_req.valid = full;
	assign out_req.mode = MODE_SINGLE;
	assign out_req.tag = hold_tag;
	assign out_req.block = {hold_digest, NONCE_PAD_WORD, 192'h0, REHASH_LEN_WORD};	// 256 bit msg

endmodule

// ==== logic/sha256_core.sv ====
// Iterative SHA-256 compression core, one round per clock, keeps a midstate for reuse
`timescale 1ns/100ps

module sha256_core (
	input logic clk,
	input logic reset,
	sha_block_if.sink req,		// Incoming block, taken only when idle
	sha_digest_if.source rsp		// Digest held until taken
);
	import sha256_pkg::*;

	core_state_e state;
	logic [$clog2(ROUND_COUNT + 2) - 1:0] round_cnt;	// 0 load, 1..64 rounds, 65 add
	sha_mode_e cur_mode;
	word_t tag;
	block_t w;				// Rolling schedule, w[0] is this round's word
	digest_t v;				// Working variables a..h
	digest_t h_start;		// Starting hash, then the result
	digest_t midstate;		// Kept from the last MODE_MID block

	logic accept;
	logic [5:0] k_idx;
	word_t t1, t2, w_next;
	digest_t start_hash, sum_hash;

	function automatic word_t rotr(input word_t x, input int unsigned n);
		logic [63:0] d;
		d = {x, x} >> n;
		return d[31:0];
	endfunction

	function automatic word_t bsig0(input word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t bsig1(input word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t ssig0(input word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t ssig1(input word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	assign accept = req.valid && req.ready;

	////////////////////////////////////////
	// Round datapath
	////////////////////////////////////////

	always_comb begin
		k_idx = 6'(round_cnt - 1'b1);		// Round 1 uses K[0]
		start_hash = (cur_mode == MODE_RESUME) ? midstate : HASH_INIT;
		t1 = v[7] + bsig1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + ROUND_K[k_idx] + w[0];
		t2 = bsig0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		w_next = ssig1(w[14]) + w[9] + ssig0(w[1]) + w[0];	// Word t+16
		for (int i = 0; i < 8; i++)
			sum_hash[i] = h_start[i] + v[i];
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			w <= req.block;
			cur_mode <= req.mode;
			tag <= req.tag;
		end else if (state == C_ROUNDS) begin
			if (round_cnt == 0) begin
				v <= start_hash;
				h_start <= start_hash;
			end else if (round_cnt <= ROUND_COUNT) begin
				v <= {t1 + t2, v[0], v[1], v[2], v[3] + t1, v[4], v[5], v[6]};
				w <= {w[1:15], w_next};
			end else begin
				h_start <= sum_hash;		// Final addition
				if (cur_mode == MODE_MID)
					midstate <= sum_hash;
			end
		end
	end

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= C_IDLE;
			round_cnt <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					round_cnt <= '0;
					if (accept)
						state <= C_ROUNDS;
				end
				C_ROUNDS: begin
					round_cnt <= round_cnt + 1'b1;
					if (round_cnt == ROUND_COUNT + 1)
						state <= (cur_mode == MODE_MID) ? C_IDLE : C_DONE;	// Midstate only
				end
				C_DONE: begin
					if (rsp.ready)
						state <= C_IDLE;
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	assign req.ready = (state == C_IDLE);		// One item at a time
	assign rsp.valid = (state == C_DONE);
	assign rsp.digest = h_start;
	assign rsp.tag = tag;

endmodule

// ==== logic/nonce_sequencer.sv ====
// Feeds the first core: one prefix block per run, then nonce blocks while run stays high
`timescale 1ns/100ps

module nonce_sequencer (
	input logic clk,
	input logic reset,
	input logic run,							// Level, keep hashing while high
	input sha256_pkg::block_t prefix_block,		// First 64 bytes of the message
	sha_block_if.source req
);
	import sha256_pkg::*;

	seq_state_e state;
	word_t nonce;		// Survives run dropping, cleared only by reset
	logic take;			// Block handed to core one this edge

	assign take = req.valid && req.ready;

	////////////////////////////////////////
	// Sequencer FSM
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			nonce <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (run)
						state <= S_PREFIX;
				end
				S_PREFIX: begin
					// Prefix gone, midstate is being built
					if (take)
						state <= run ? S_NONCE : S_IDLE;
				end
				S_NONCE: begin
					if (take) begin
						nonce <= nonce + 1'b1;
						state <= run ? S_NONCE : S_IDLE;	// Idle means prefix again next run
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Request fields follow the state directly
	assign req.valid = (state != S_IDLE);
	assign req.mode = (state == S_PREFIX) ? MODE_MID : MODE_RESUME;
	assign req.tag = nonce;

	// Nonce block: nonce, pad bit, zeros, 544 bit length
	assign req.block = (state == S_PREFIX) ? prefix_block :
		{nonce, NONCE_PAD_WORD, 416'h0, NONCE_LEN_WORD};

endmodule

// ==== logic/sha_if.sv ====
// Valid/ready links between pipeline stages; blocks go into a core, digests come out of one
`timescale 1ns/100ps

// Message block request, tagged with its nonce
interface sha_block_if;
	import sha256_pkg::*;

	logic valid;
	logic ready;
	sha_mode_e mode;		// How the core starts and ends
	block_t block;
	word_t tag;				// Nonce riding along

	// Fields held steady while valid && !ready
	modport source (output valid, output mode, output block, output tag, input ready);
	modport sink (input valid, input mode, input block, input tag, output ready);

endinterface

// Digest return, same handshake as the block link
interface sha_digest_if;
	import sha256_pkg::*;

	logic valid;
	logic ready;
	digest_t digest;
	word_t tag;

	modport source (output valid, output digest, output tag, input ready);
	modport sink (input valid, input digest, input tag, output ready);

endinterface

// ==== logic/sha256_pkg.sv ====
// Shared SHA-256 types, constants and enums; imported by every stage of the double-hash engine
package sha256_pkg;

	typedef logic [31:0] word_t;		// One SHA-256 word
	typedef word_t [0:15] block_t;		// Word 0 in the top bits
	typedef word_t [0:7] digest_t;		// Hash value, word 0 first

	////////////////////////////////////////
	// FIPS 180-4 constants
	////////////////////////////////////////

	localparam word_t [0:63] ROUND_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam digest_t HASH_INIT = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam int ROUND_COUNT = 64;		// Compression rounds per block

	// Padding for the two message shapes used here
	localparam word_t NONCE_PAD_WORD = 32'h8000_0000;	// Single 1 bit after the message
	localparam word_t NONCE_LEN_WORD = 32'h0000_0220;	// 68 bytes = 544 bits
	localparam word_t REHASH_LEN_WORD = 32'h0000_0100;	// 32 bytes = 256 bits

	localparam int OP_COUNT_WIDTH = 48;

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	typedef enum logic [1:0] {
		MODE_MID,		// Init start, keep result as midstate, no digest out
		MODE_RESUME,	// Midstate start, digest out, midstate untouched
		MODE_SINGLE		// Init start, digest out
	} sha_mode_e;

	typedef enum logic [1:0] {S_IDLE, S_PREFIX, S_NONCE} seq_state_e;

	typedef enum logic [1:0] {C_IDLE, C_ROUNDS, C_DONE} core_state_e;

endpackage
